/* build.f */
fetch_pkg.sv
inst_cache.sv
branch_predictor.sv
fetch_queue.sv
fetch_ctrl.sv
fetch_top.sv
tb_fetch_top.sv

/* run.sh */
#!/bin/sh
# build with verilator and run; the run passes only if the pass line shows up.
verilator --binary --timing -Wno-fatal --top-module tb_fetch_top -f build.f -o sim_fetch \
    && ./obj_dir/sim_fetch | tee /dev/stderr | grep -q "TEST OK" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    localparam int          n_rows    = 28;
    localparam logic [31:0] branch_pc = 32'h20;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        pred_taken;
        logic        rand_ready;    // out_ready toggles at random.
        logic        upd;           // one taken update for the branch before this packet.
        logic        redir;         // redirect to this row's pc first.
        logic        redir_on_miss;
    } row_t;

    logic                     clk_in;
    logic                     rst_in;
    logic                     mem_req_valid;
    logic                     mem_req_ready;
    fetch_pkg::mem_req_t      mem_req;
    logic                     mem_resp_valid;
    fetch_pkg::mem_resp_t     mem_resp;
    logic                     out_valid;
    logic                     out_ready;
    fetch_pkg::fetch_packet_t out_packet;
    logic                     redirect_valid;
    logic [31:0]              redirect_pc;
    logic                     bp_update_valid;
    fetch_pkg::bp_update_t    bp_update;

    logic [31:0] rom [16];
    logic [15:0] requested;     // one bit per program word.
    row_t        rows [n_rows];
    int          n_added;
    int          value_errors;
    int          mem_errors;
    int          pending;
    int          lat_left;
    logic [31:0] req_addr;

    fetch_top i_fetch_top (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req         (mem_req),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp        (mem_resp),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_packet      (out_packet),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .bp_update_valid (bp_update_valid),
        .bp_update       (bp_update)
    );

    // jal x0 and beq x0, x0 built from a byte offset.
    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic add_row(input logic [31:0] row_pc, input logic taken, input logic rnd,
                           input logic upd, input logic redir, input logic on_miss);
        rows[n_added] = '{pc: row_pc, inst: rom[row_pc[5:2]], pred_taken: taken,
                          rand_ready: rnd, upd: upd, redir: redir, redir_on_miss: on_miss};
        n_added++;
    endtask

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // ====================
    // memory model
    // ====================
    initial begin : memory_model
        forever begin
            @(posedge clk_in);
            #1;
            mem_resp_valid = 1'b0;
            if (lat_left > 0) begin
                lat_left--;
                if (lat_left == 0) begin
                    pending        = 0;
                    mem_resp_valid = 1'b1;
                    mem_resp.addr  = req_addr;
                    mem_resp.inst  = rom[req_addr[5:2]];
                end
            end
            mem_req_ready = ($urandom_range(0, 3) != 0);
            @(negedge clk_in);
            if (mem_req_valid && mem_req_ready && !rst_in) begin
                if (pending != 0) begin
                    $display("memory request for %h while another one is outstanding",
                             mem_req.addr);
                    mem_errors++;
                end
                if (mem_req.addr >= 32'd64 || requested[mem_req.addr[5:2]]) begin
                    $display("memory request for %h repeats a fetched pc or leaves the program",
                             mem_req.addr);
                    mem_errors++;
                end else begin
                    requested[mem_req.addr[5:2]] = 1'b1;
                end
                pending++;
                req_addr = mem_req.addr;
                lat_left = $urandom_range(1, 4);
            end
        end
    end

    initial begin : watchdog
        repeat (n_rows * 40) @(posedge clk_in);
        $display("watchdog expired before all expected packets were delivered");
        $display("TEST FAILED");
        $finish;
    end

    // ====================
    // stimulus and checks
    // ====================
    initial begin
        row_t                     row;
        fetch_pkg::fetch_packet_t got;
        logic                     done;

        void'($urandom(32'h7f1d_d47c));
        rst_in          = 1'b1;
        mem_req_ready   = 1'b0;
        mem_resp_valid  = 1'b0;
        mem_resp        = '0;
        out_ready       = 1'b0;
        redirect_valid  = 1'b0;
        redirect_pc     = '0;
        bp_update_valid = 1'b0;
        bp_update       = '0;
        value_errors    = 0;
        mem_errors      = 0;
        pending         = 0;
        lat_left        = 0;
        req_addr        = '0;
        requested       = '0;
        n_added         = 0;

        // addi x1, x1, addr at every word, then the branch and the jal back to 0.
        for (int a = 0; a < 16; a++) begin
            rom[a] = {12'(4 * a), 5'd1, 3'b000, 5'd1, 7'b0010011};
        end
        rom[8]  = enc_beq(13'd8);
        rom[11] = enc_jal(-21'd44);

        for (int i = 0; i < 12; i++) begin          // first pass, branch falls through.
            add_row(32'(4 * i), i == 11, i[0], i == 10 || i == 11, 1'b0, 1'b0);
        end
        for (int i = 0; i < 12; i++) begin          // second pass, branch now taken.
            if (i != 9) begin
                add_row(32'(4 * i), i == 8 || i == 11, i % 3 == 0, 1'b0, 1'b0, 1'b0);
            end
        end
        add_row(32'h30, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        add_row(32'h24, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        add_row(32'h28, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row(32'h2c, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row(32'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

        repeat (3) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        for (int r = 0; r < n_rows; r++) begin
            row = rows[r];
            @(posedge clk_in);      // takes the previous packet.
            #1;
            out_ready = 1'b0;
            if (row.upd) begin
                bp_update_valid = 1'b1;
                bp_update.pc    = branch_pc;
                bp_update.taken = 1'b1;
                @(posedge clk_in);
                #1;
                bp_update_valid = 1'b0;
            end
            if (row.redir) begin
                if (row.redir_on_miss) begin
                    @(negedge clk_in);
                    while (!mem_req_valid) @(negedge clk_in);
                    @(posedge clk_in);
                    #1;
                end
                redirect_valid = 1'b1;
                redirect_pc    = row.pc;
                @(posedge clk_in);
                #1;
                redirect_valid = 1'b0;
            end
            done = 1'b0;
            while (!done) begin
                out_ready = row.rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
                @(negedge clk_in);
                if (out_valid && out_ready) begin
                    got  = out_packet;
                    done = 1'b1;
                end else begin
                    @(posedge clk_in);
                    #1;
                end
            end
            if (got.pc !== row.pc) begin
                $display("** Error: out_packet.pc expected %h got %h", row.pc, got.pc);
                value_errors++;
            end
            if (got.inst !== row.inst) begin
                $display("** Error: out_packet.inst expected %h got %h", row.inst, got.inst);
                value_errors++;
            end
            if (got.pred_taken !== row.pred_taken) begin
                $display("** Error: out_packet.pred_taken expected %h got %h",
                         row.pred_taken, got.pred_taken);
                value_errors++;
            end
        end
        @(posedge clk_in);
        #1;
        out_ready = 1'b0;

        $display("value errors: %0d, memory errors: %0d", value_errors, mem_errors);
        if (value_errors == 0 && mem_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  wire                              clk_in,
    input  wire                              rst_in,
    output logic                             mem_req_valid,
    input  wire                              mem_req_ready,
    output fetch_pkg::mem_req_t              mem_req,
    input  wire                              mem_resp_valid,
    input  wire fetch_pkg::mem_resp_t        mem_resp,
    output logic                             out_valid,
    input  wire                              out_ready,
    output fetch_pkg::fetch_packet_t         out_packet,
    input  wire                              redirect_valid,
    input  wire [fetch_pkg::xlen-1:0]        redirect_pc,
    input  wire                              bp_update_valid,
    input  wire fetch_pkg::bp_update_t       bp_update
);

    logic [fetch_pkg::xlen-1:0]   pc;
    logic [fetch_pkg::xlen-1:0]   cur_inst;
    logic                         hit;
    logic [fetch_pkg::xlen-1:0]   hit_inst;
    logic                         pred_taken;
    logic [fetch_pkg::xlen-1:0]   pred_next_pc;
    logic                         cache_fill_valid;
    fetch_pkg::cache_fill_t       cache_fill;
    logic                         push_valid;
    logic                         push_ready;
    fetch_pkg::fetch_packet_t     push_packet;
    logic                         flush;

    fetch_ctrl i_fetch_ctrl (
        .clk_in           (clk_in),
        .rst_in           (rst_in),
        .hit              (hit),
        .hit_inst         (hit_inst),
        .pred_taken       (pred_taken),
        .pred_next_pc     (pred_next_pc),
        .mem_req_ready    (mem_req_ready),
        .mem_resp_valid   (mem_resp_valid),
        .mem_resp         (mem_resp),
        .push_ready       (push_ready),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .pc               (pc),
        .cache_fill_valid (cache_fill_valid),
        .cache_fill       (cache_fill),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .push_valid       (push_valid),
        .push_packet      (push_packet),
        .flush            (flush),
        .cur_inst         (cur_inst)
    );

    inst_cache i_inst_cache (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .lookup_pc  (pc),
        .fill_valid (cache_fill_valid),
        .fill       (cache_fill),
        .hit        (hit),
        .hit_inst   (hit_inst)
    );

    branch_predictor i_branch_predictor (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .pc           (pc),
        .inst         (cur_inst),
        .update_valid (bp_update_valid),
        .update       (bp_update),
        .pred_taken   (pred_taken),
        .pred_next_pc (pred_next_pc)
    );

    fetch_queue i_fetch_queue (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .flush       (flush),
        .push_valid  (push_valid),
        .push_packet (push_packet),
        .out_ready   (out_ready),
        .push_ready  (push_ready),
        .out_valid   (out_valid),
        .out_packet  (out_packet)
    );

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  wire                              clk_in,
    input  wire                              rst_in,
    input  wire                              hit,
    input  wire [fetch_pkg::xlen-1:0]        hit_inst,
    input  wire                              pred_taken,
    input  wire [fetch_pkg::xlen-1:0]        pred_next_pc,
    input  wire                              mem_req_ready,
    input  wire                              mem_resp_valid,
    input  wire fetch_pkg::mem_resp_t        mem_resp,
    input  wire                              push_ready,
    input  wire                              redirect_valid,
    input  wire [fetch_pkg::xlen-1:0]        redirect_pc,
    output logic [fetch_pkg::xlen-1:0]       pc,
    output logic                             cache_fill_valid,
    output fetch_pkg::cache_fill_t           cache_fill,
    output logic                             mem_req_valid,
    output fetch_pkg::mem_req_t              mem_req,
    output logic                             push_valid,
    output fetch_pkg::fetch_packet_t         push_packet,
    output logic                             flush,
    output logic [fetch_pkg::xlen-1:0]       cur_inst
);

    fetch_pkg::fetch_state_t          state;
    logic                             resp_held;    // reply parked while queue is full.
    logic [fetch_pkg::xlen-1:0]       resp_inst;
    logic                             resp_match;
    logic                             resp_avail;
    logic                             hit_fire;
    logic                             fill_fire;
    logic                             req_pending;
    logic [fetch_pkg::xlen-1:0]       fill_inst;

    // ====================
    // datapath
    // ====================
    assign resp_match = (state == fetch_pkg::wait_resp) && mem_resp_valid
                        && (mem_resp.addr == pc);
    assign resp_avail = (state == fetch_pkg::wait_resp) && (resp_held || resp_match);

    assign fill_inst = resp_held ? resp_inst : mem_resp.inst;
    assign cur_inst  = (state == fetch_pkg::idle) ? hit_inst : fill_inst;

    assign hit_fire  = (state == fetch_pkg::idle) && hit && push_ready;
    assign fill_fire = resp_avail && push_ready;

    // a reply is still owed to us after this cycle.
    assign req_pending = ((state == fetch_pkg::request) && mem_req_ready)
                       || (((state == fetch_pkg::wait_resp) && !resp_held)
                           || (state == fetch_pkg::drain)) && !mem_resp_valid;

    assign push_valid       = ((state == fetch_pkg::idle) && hit) || resp_avail;
    assign cache_fill_valid = fill_fire;
    assign mem_req_valid    = (state == fetch_pkg::request);
    assign flush            = redirect_valid;

    always_comb begin
        push_packet.pc         = pc;
        push_packet.inst       = cur_inst;
        push_packet.pred_taken = pred_taken;
        cache_fill.addr        = pc;
        cache_fill.inst        = fill_inst;
        mem_req.addr           = pc;   // held steady while in request.
    end

    // ====================
    // state machine
    // ====================
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= fetch_pkg::idle;
            pc        <= '0;
            resp_held <= 1'b0;
        end else if (redirect_valid) begin
            pc        <= redirect_pc;
            resp_held <= 1'b0;
            state     <= req_pending ? fetch_pkg::drain : fetch_pkg::idle;
        end else begin
            case (state)
                fetch_pkg::idle: begin
                    if (hit_fire) begin
                        pc <= pred_next_pc;
                    end else if (!hit) begin
                        state <= fetch_pkg::request;
                    end
                end
                fetch_pkg::request: begin
                    if (mem_req_ready) begin
                        state <= fetch_pkg::wait_resp;
                    end
                end
                fetch_pkg::wait_resp: begin
                    if (fill_fire) begin
                        pc        <= pred_next_pc;
                        resp_held <= 1'b0;
                        state     <= fetch_pkg::idle;
                    end else if (resp_match) begin
                        resp_held <= 1'b1;
                    end
                end
                fetch_pkg::drain: begin
                    if (mem_resp_valid) begin
                        state <= fetch_pkg::idle;   // stale reply dropped.
                    end
                end
                default: state <= fetch_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (resp_match && !resp_held) begin
            resp_inst <= mem_resp.inst;
        end
    end

endmodule

`default_nettype wire

/* fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  wire                              clk_in,
    input  wire                              rst_in,
    input  wire                              flush,
    input  wire                              push_valid,
    input  wire fetch_pkg::fetch_packet_t    push_packet,
    input  wire                              out_ready,
    output logic                             push_ready,
    output logic                             out_valid,
    output fetch_pkg::fetch_packet_t         out_packet
);

    fetch_pkg::fetch_packet_t                entry [fetch_pkg::queue_depth];
    logic [fetch_pkg::queue_ptr_bits-1:0]    wr_ptr;
    logic [fetch_pkg::queue_ptr_bits-1:0]    rd_ptr;
    logic [fetch_pkg::queue_count_bits-1:0]  count;
    logic                                    push_fire;
    logic                                    pop_fire;

    assign push_ready = (count != fetch_pkg::queue_count_bits'(fetch_pkg::queue_depth));
    assign out_valid  = (count != '0);
    assign out_packet = entry[rd_ptr];

    assign push_fire = push_valid && push_ready;
    assign pop_fire  = out_valid && out_ready;

    // ====================
    // pointers and count
    // ====================
    always_ff @(posedge clk_in) begin
        if (rst_in || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth.
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (push_fire) begin
            entry[wr_ptr] <= push_packet;
        end
    end

endmodule

`default_nettype wire

/* branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire                              clk_in,
    input  wire                              rst_in,
    input  wire [fetch_pkg::xlen-1:0]        pc,
    input  wire [fetch_pkg::xlen-1:0]        inst,
    input  wire                              update_valid,
    input  wire fetch_pkg::bp_update_t       update,
    output logic                             pred_taken,
    output logic [fetch_pkg::xlen-1:0]       pred_next_pc
);

    logic [1:0]                          counter [fetch_pkg::bp_entries];
    logic [fetch_pkg::bp_index_bits-1:0] rd_index;
    logic [fetch_pkg::bp_index_bits-1:0] up_index;
    logic                                is_jal;
    logic                                is_branch;
    logic [fetch_pkg::xlen-1:0]          j_imm;
    logic [fetch_pkg::xlen-1:0]          b_imm;

    assign rd_index  = pc[fetch_pkg::bp_index_bits+1:2];
    assign up_index  = update.pc[fetch_pkg::bp_index_bits+1:2];
    assign is_jal    = (inst[6:0] == fetch_pkg::op_jal);
    assign is_branch = (inst[6:0] == fetch_pkg::op_branch);

    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    // jal always taken, branch follows the counter msb.
    assign pred_taken   = is_jal || (is_branch && counter[rd_index][1]);
    assign pred_next_pc = !pred_taken ? pc + 32'd4
                        : is_jal      ? pc + j_imm
                        :               pc + b_imm;

    // ====================
    // training
    // ====================
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < fetch_pkg::bp_entries; i++) begin
                counter[i] <= 2'b01;   // weakly not taken.
            end
        end else if (update_valid) begin
            if (update.taken && counter[up_index] != 2'b11) begin
                counter[up_index] <= counter[up_index] + 2'b01;
            end else if (!update.taken && counter[up_index] != 2'b00) begin
                counter[up_index] <= counter[up_index] - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

/* inst_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_cache (
    input  wire                              clk_in,
    input  wire                              rst_in,
    input  wire [fetch_pkg::xlen-1:0]        lookup_pc,
    input  wire                              fill_valid,
    input  wire fetch_pkg::cache_fill_t      fill,
    output logic                             hit,
    output logic [fetch_pkg::xlen-1:0]       hit_inst
);

    logic [fetch_pkg::icache_lines-1:0]      line_valid;
    logic [fetch_pkg::icache_tag_bits-1:0]   line_tag  [fetch_pkg::icache_lines];
    logic [fetch_pkg::xlen-1:0]              line_inst [fetch_pkg::icache_lines];

    logic [fetch_pkg::icache_index_bits-1:0] rd_index;
    logic [fetch_pkg::icache_tag_bits-1:0]   rd_tag;
    logic [fetch_pkg::icache_index_bits-1:0] wr_index;
    logic [fetch_pkg::icache_tag_bits-1:0]   wr_tag;

    // index is pc[5:2], tag is everything above.
    assign rd_index = lookup_pc[fetch_pkg::icache_index_bits+1:2];
    assign rd_tag   = lookup_pc[fetch_pkg::xlen-1:fetch_pkg::icache_index_bits+2];
    assign wr_index = fill.addr[fetch_pkg::icache_index_bits+1:2];
    assign wr_tag   = fill.addr[fetch_pkg::xlen-1:fetch_pkg::icache_index_bits+2];

    // combinational lookup.
    assign hit      = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);
    assign hit_inst = line_inst[rd_index];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            line_valid <= '0;
        end else if (fill_valid) begin
            line_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (fill_valid) begin
            line_tag[wr_index]  <= wr_tag;
            line_inst[wr_index] <= fill.inst;
        end
    end

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // ====================
    // widths and opcodes
    // ====================
    localparam int xlen = 32;

    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // ====================
    // sizes
    // ====================
    localparam int icache_lines      = 16;
    localparam int icache_index_bits = 4;   // pc[5:2].
    localparam int icache_tag_bits   = xlen - icache_index_bits - 2;

    localparam int bp_entries    = 32;
    localparam int bp_index_bits = 5;       // pc[6:2].

    localparam int queue_depth      = 4;
    localparam int queue_ptr_bits   = 2;
    localparam int queue_count_bits = 3;    // 0 .. queue_depth.

    // ====================
    // shared structs
    // ====================
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            pred_taken;
    } fetch_packet_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] inst;
    } mem_resp_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            taken;
    } bp_update_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] inst;
    } cache_fill_t;

    typedef enum logic [1:0] {
        idle      = 2'd0,
        request   = 2'd1,
        wait_resp = 2'd2,
        drain     = 2'd3
    } fetch_state_t;

endpackage

`default_nettype wire
